// ==== board_defines.svh ====
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// ******************************
// Tick timer
// ******************************

// Clock cycles per tick, kept short for simulation
// A one second tick on a 50 MHz board clock needs 50000000 here
`define TICK_DIV 8

// Modulus of the up counter, so the count always fits two decimal digits
`define COUNT_WRAP 100

// ******************************
// PS/2 receiver
// ******************************

// Start bit, eight data bits LSB first, odd parity, stop bit
`define PS2_FRAME_BITS 11

`endif

// ==== board_pkg.sv ====
package board_pkg;

    // ******************************
    // ALU
    // ******************************

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_NOT = 3'd2,  // Inverts operand a only
        ALU_AND = 3'd3,
        ALU_OR  = 3'd4,
        ALU_XOR = 3'd5,
        ALU_SLT = 3'd6,  // Two's complement compare
        ALU_EQ  = 3'd7
    } alu_op_e;

    typedef struct packed {
        logic zero;
        logic carry;     // Borrow when subtracting
        logic overflow;
    } alu_flags_t;

    // ******************************
    // Keyboard and display
    // ******************************

    typedef struct packed {
        logic [7:0] code;   // Last scan code received without error
        logic       ready;
        logic       error;
    } key_event_t;

    // Everything the display shows, gathered at the top level
    typedef struct packed {
        logic [7:0] count;
        logic [2:0] down;
        logic [7:0] key_code;
        logic [3:0] alu_res;
        alu_flags_t flags;
    } disp_in_t;

endpackage

// ==== ps2_keyboard.sv ====
`timescale 1ns/1ps
`include "board_defines.svh"

module ps2_keyboard (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ps2_clk,
    input  logic                  ps2_data,
    output board_pkg::key_event_t key
);

    localparam int CNT_W = $clog2(`PS2_FRAME_BITS);

    logic                         clk_s1;
    logic                         clk_s2;
    logic                         clk_d;
    logic                         data_s1;
    logic                         data_s2;
    logic                         fall;
    logic                         last_bit;
    logic                         frame_done;
    logic                         frame_ok;
    logic [CNT_W-1:0]             bit_cnt;
    logic [`PS2_FRAME_BITS-2:0]   shift_q;
    logic [`PS2_FRAME_BITS-1:0]   frame;

    // ******************************
    // Pin synchronizers
    // ******************************

    // The PS/2 clock idles high, so reset to 1 to avoid a false edge
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_s1 <= 1'b1;
            clk_s2 <= 1'b1;
            clk_d  <= 1'b1;
        end else begin
            clk_s1 <= ps2_clk;
            clk_s2 <= clk_s1;
            clk_d  <= clk_s2;  // Edge detect stage
        end
    end

    always_ff @(posedge clk) begin
        data_s1 <= ps2_data;
        data_s2 <= data_s1;
    end

    assign fall     = clk_d & ~clk_s2;
    assign last_bit = (bit_cnt == CNT_W'(`PS2_FRAME_BITS - 1));
    assign frame_done = fall & last_bit;

    // ******************************
    // Frame assembly
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (fall) begin
            bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
        end
    end

    // Bits arrive LSB first and enter from the top
    always_ff @(posedge clk) begin
        if (fall) begin
            shift_q <= {data_s2, shift_q[`PS2_FRAME_BITS-2:1]};
        end
    end

    // Stop bit is the one being sampled right now
    assign frame = {data_s2, shift_q};

    // Start low, stop high, odd parity over data and parity bits
    assign frame_ok = ~frame[0] & frame[`PS2_FRAME_BITS-1] & (^frame[`PS2_FRAME_BITS-2:1]);

    always_ff @(posedge clk) begin
        if (rst) begin
            key.code  <= 8'h00;
            key.ready <= 1'b0;
            key.error <= 1'b0;
        end else begin
            key.ready <= frame_done & frame_ok;
            key.error <= frame_done & ~frame_ok;
            if (frame_done && frame_ok) begin
                key.code <= frame[8:1];
            end
        end
    end

    a_ready_one_cycle: assert property (@(posedge clk) disable iff (rst)
        key.ready |=> !key.ready);

    a_error_one_cycle: assert property (@(posedge clk) disable iff (rst)
        key.error |=> !key.error);

endmodule

// ==== tick_counter.sv ====
`timescale 1ns/1ps
`include "board_defines.svh"

module tick_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       counter_en,
    output logic [7:0] inc_count,
    output logic [2:0] dec_count
);

    localparam int DIV_W = (`TICK_DIV > 1) ? $clog2(`TICK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic             div_last;
    logic             tick;

    // ******************************
    // Prescaler
    // ******************************

    assign div_last = (div_cnt == DIV_W'(`TICK_DIV - 1));

    // Free running, the enable only gates the counters below
    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            div_cnt <= div_last ? '0 : div_cnt + 1'b1;
            tick    <= div_last;
        end
    end

    // ******************************
    // Event counters
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            inc_count <= 8'd0;
            dec_count <= 3'd0;
        end else if (tick && counter_en) begin
            inc_count <= (inc_count == 8'(`COUNT_WRAP - 1)) ? 8'd0 : inc_count + 8'd1;
            dec_count <= dec_count - 3'd1;  // Wraps 0 to 7 on its own
        end
    end

    // The display splits this into two decimal digits
    a_count_range: assert property (@(posedge clk) disable iff (rst)
        inc_count < 8'(`COUNT_WRAP));

endmodule

// ==== alu_4bit.sv ====
`timescale 1ns/1ps

module alu_4bit (
    input  board_pkg::alu_op_e    alu_fnselec,
    input  logic [3:0]            alu_a,
    input  logic [3:0]            alu_b,
    output logic [3:0]            alu_res,
    output board_pkg::alu_flags_t flags
);

    import board_pkg::*;

    logic [4:0] sum;
    logic [4:0] diff;
    logic       add_ovf;
    logic       sub_ovf;

    assign sum  = {1'b0, alu_a} + {1'b0, alu_b};
    assign diff = {1'b0, alu_a} - {1'b0, alu_b};  // Bit 4 set when a < b unsigned

    // Signed overflow when the result sign disagrees with what the operand signs allow
    assign add_ovf = (alu_a[3] == alu_b[3]) && (sum[3] != alu_a[3]);
    assign sub_ovf = (alu_a[3] != alu_b[3]) && (diff[3] != alu_a[3]);

    always_comb begin
        flags.carry    = 1'b0;
        flags.overflow = 1'b0;
        case (alu_fnselec)
            ALU_ADD: begin
                alu_res        = sum[3:0];
                flags.carry    = sum[4];
                flags.overflow = add_ovf;
            end
            ALU_SUB: begin
                alu_res        = diff[3:0];
                flags.carry    = diff[4];
                flags.overflow = sub_ovf;
            end
            ALU_NOT: alu_res = ~alu_a;
            ALU_AND: alu_res = alu_a & alu_b;
            ALU_OR:  alu_res = alu_a | alu_b;
            ALU_XOR: alu_res = alu_a ^ alu_b;
            ALU_SLT: begin
                alu_res = {3'b000, $signed(alu_a) < $signed(alu_b)};
            end
            ALU_EQ: begin
                alu_res = {3'b000, alu_a == alu_b};
            end
            default: alu_res = 4'd0;
        endcase
        flags.zero = (alu_res == 4'd0);
    end

endmodule

// ==== seg_display.sv ====
`timescale 1ns/1ps

module seg_display (
    input  logic                clk,
    input  logic                rst,
    input  board_pkg::disp_in_t disp,
    output logic [7:0]          seg0,
    output logic [7:0]          seg1,
    output logic [7:0]          seg2,
    output logic [7:0]          seg3,
    output logic [7:0]          seg4,
    output logic [7:0]          seg5,
    output logic [7:0]          seg6,
    output logic [7:0]          seg7
);

    logic [3:0]      ones;
    logic [3:0]      tens;
    logic [7:0]      flag_seg;
    logic [7:0][7:0] seg_d;
    logic [7:0][7:0] seg_q;

    // Active low, bit 0 is segment a and bit 6 is segment g, point off
    function automatic logic [7:0] hex_to_seg(input logic [3:0] value);
        logic [6:0] pat;
        case (value)
            4'h0: pat = 7'h40;
            4'h1: pat = 7'h79;
            4'h2: pat = 7'h24;
            4'h3: pat = 7'h30;
            4'h4: pat = 7'h19;
            4'h5: pat = 7'h12;
            4'h6: pat = 7'h02;
            4'h7: pat = 7'h78;
            4'h8: pat = 7'h00;
            4'h9: pat = 7'h10;
            4'hA: pat = 7'h08;
            4'hB: pat = 7'h03;
            4'hC: pat = 7'h46;
            4'hD: pat = 7'h21;
            4'hE: pat = 7'h06;
            4'hF: pat = 7'h0E;
        endcase
        return {1'b1, pat};
    endfunction

    // ******************************
    // Digit selection
    // ******************************

    assign ones = 4'(disp.count % 8'd10);
    assign tens = 4'(disp.count / 8'd10);

    assign flag_seg = hex_to_seg({1'b0, disp.flags});

    assign seg_d[0] = hex_to_seg(ones);
    assign seg_d[1] = hex_to_seg(tens);
    assign seg_d[2] = hex_to_seg({1'b0, disp.down});
    assign seg_d[3] = hex_to_seg(disp.key_code[3:0]);
    assign seg_d[4] = hex_to_seg(disp.key_code[7:4]);
    assign seg_d[5] = hex_to_seg(disp.alu_res);
    assign seg_d[6] = 8'hFF;  // Unused digit stays dark
    assign seg_d[7] = {~(|disp.flags), flag_seg[6:0]};  // Point lights on any flag

    always_ff @(posedge clk) begin
        if (rst) begin
            seg_q <= '1;  // All digits blank
        end else begin
            seg_q <= seg_d;
        end
    end

    assign seg0 = seg_q[0];
    assign seg1 = seg_q[1];
    assign seg2 = seg_q[2];
    assign seg3 = seg_q[3];
    assign seg4 = seg_q[4];
    assign seg5 = seg_q[5];
    assign seg6 = seg_q[6];
    assign seg7 = seg_q[7];

endmodule

// ==== top.sv ====
`timescale 1ns/1ps

module top (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic [7:0] sw,
    input  logic [2:0] alu_fnselec,
    input  logic       counter_en,
    output logic [7:0] key_code,
    output logic       key_ready,
    output logic       key_error,
    output logic [3:0] alu_res,
    output logic       alu_zero,
    output logic       alu_carry,
    output logic       alu_overflow,
    output logic [7:0] inc_count,
    output logic [2:0] dec_count,
    output logic [7:0] seg0,
    output logic [7:0] seg1,
    output logic [7:0] seg2,
    output logic [7:0] seg3,
    output logic [7:0] seg4,
    output logic [7:0] seg5,
    output logic [7:0] seg6,
    output logic [7:0] seg7
);

    import board_pkg::*;

    key_event_t key;
    alu_op_e    alu_op;
    alu_flags_t flags;
    disp_in_t   disp;

    ps2_keyboard u_keyboard (
        .clk      (clk),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .key      (key)
    );

    tick_counter u_counter (
        .clk        (clk),
        .rst        (rst),
        .counter_en (counter_en),
        .inc_count  (inc_count),
        .dec_count  (dec_count)
    );

    assign alu_op = alu_op_e'(alu_fnselec);

    // Low switches are operand a, high switches operand b
    alu_4bit u_alu (
        .alu_fnselec (alu_op),
        .alu_a       (sw[3:0]),
        .alu_b       (sw[7:4]),
        .alu_res     (alu_res),
        .flags       (flags)
    );

    assign disp = '{count: inc_count, down: dec_count, key_code: key.code,
                    alu_res: alu_res, flags: flags};

    seg_display u_display (
        .clk  (clk),
        .rst  (rst),
        .disp (disp),
        .seg0 (seg0),
        .seg1 (seg1),
        .seg2 (seg2),
        .seg3 (seg3),
        .seg4 (seg4),
        .seg5 (seg5),
        .seg6 (seg6),
        .seg7 (seg7)
    );

    assign key_code     = key.code;
    assign key_ready    = key.ready;
    assign key_error    = key.error;
    assign alu_zero     = flags.zero;
    assign alu_carry    = flags.carry;
    assign alu_overflow = flags.overflow;

endmodule

// ==== tb_top.sv ====
`timescale 1ns/1ps
`include "board_defines.svh"

module tb_top;

    localparam int CLK_PERIOD  = 20;
    localparam int PS2_HALF    = 10;   // clk cycles per PS/2 clock half period
    localparam int NUM_VEC     = 15;
    localparam int NUM_RANDOM  = 24;
    localparam int COUNT_TICKS = 107;  // Runs past the wrap at 100
    localparam int FRAME_CYCLES = `PS2_FRAME_BITS * 2 * PS2_HALF + 40;
    localparam int TIMEOUT_CYCLES = NUM_VEC * FRAME_CYCLES + NUM_RANDOM * 4
                                  + (COUNT_TICKS + 5) * `TICK_DIV + 500;

    // Active low a to g, point off
    localparam logic [7:0] SEG_HEX [16] = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92,
        8'h82, 8'hF8, 8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};

    typedef struct packed {
        logic       is_key;  // PS/2 frame when set, ALU vector otherwise
        logic [2:0] op;
        logic [7:0] data;    // {b, a} for the ALU, the byte for a frame
        logic [1:0] fault;   // 1 flips parity, 2 clears the stop bit
        logic [3:0] res;
        logic [2:0] flags;   // {zero, carry, overflow}
        logic       err;
    } vector_t;

    vector_t vectors [NUM_VEC] = '{
        '{1'b0, 3'd0, 8'h35, 2'd0, 4'h8, 3'b001, 1'b0},
        '{1'b0, 3'd0, 8'h1F, 2'd0, 4'h0, 3'b110, 1'b0},
        '{1'b0, 3'd0, 8'h88, 2'd0, 4'h0, 3'b111, 1'b0},
        '{1'b0, 3'd1, 8'h53, 2'd0, 4'hE, 3'b010, 1'b0},
        '{1'b0, 3'd1, 8'h18, 2'd0, 4'h7, 3'b001, 1'b0},
        '{1'b1, 3'd0, 8'h1C, 2'd0, 4'h0, 3'b000, 1'b0},
        '{1'b1, 3'd0, 8'h5A, 2'd1, 4'h0, 3'b000, 1'b1},
        '{1'b0, 3'd2, 8'h3A, 2'd0, 4'h5, 3'b000, 1'b0},
        '{1'b0, 3'd3, 8'hAC, 2'd0, 4'h8, 3'b000, 1'b0},
        '{1'b1, 3'd0, 8'hF0, 2'd0, 4'h0, 3'b000, 1'b0},
        '{1'b1, 3'd0, 8'h32, 2'd2, 4'h0, 3'b000, 1'b1},
        '{1'b0, 3'd5, 8'h99, 2'd0, 4'h0, 3'b100, 1'b0},
        '{1'b0, 3'd6, 8'h1F, 2'd0, 4'h1, 3'b000, 1'b0},
        '{1'b1, 3'd0, 8'h00, 2'd0, 4'h0, 3'b000, 1'b0},
        '{1'b0, 3'd7, 8'h77, 2'd0, 4'h1, 3'b000, 1'b0}
    };

    logic clk = 1'b0;
    logic rst, ps2_clk, ps2_data, counter_en;
    logic [7:0] sw;
    logic [2:0] alu_fnselec;
    logic [7:0] key_code, inc_count;
    logic       key_ready, key_error, alu_zero, alu_carry, alu_overflow;
    logic [3:0] alu_res;
    logic [2:0] dec_count;
    logic [7:0] seg0, seg1, seg2, seg3, seg4, seg5, seg6, seg7;
    logic [7:0] lfsr = 8'd96;
    logic [7:0] last_code = 8'h00;
    int         ready_cnt = 0;
    int         error_cnt = 0;

    top UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge clk) begin
        if (key_ready) ready_cnt <= ready_cnt + 1;
        if (key_error) error_cnt <= error_cnt + 1;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Watchdog expired, the run timed out before all tests finished");
        $display("tests failed");
        $fatal(1, "timeout");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %h expected %h", name, got, expected);
            $display("tests failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] value);
        value = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    // Reference ALU in integer arithmetic, returns {res, zero, carry, overflow}
    function automatic logic [6:0] alu_model(input logic [2:0] op, input logic [3:0] a,
                                             input logic [3:0] b);
        int sa;
        int sb;
        int r;
        logic [3:0] res;
        logic carry;
        logic ovf;
        sa = (a > 7) ? int'(a) - 16 : int'(a);
        sb = (b > 7) ? int'(b) - 16 : int'(b);
        carry = 1'b0;
        ovf = 1'b0;
        case (op)
            3'd0: begin
                r = int'(a) + int'(b);
                carry = (r > 15);
                ovf = (sa + sb > 7) || (sa + sb < -8);
            end
            3'd1: begin
                r = int'(a) - int'(b);
                carry = (a < b);
                ovf = (sa - sb > 7) || (sa - sb < -8);
            end
            3'd2: r = 15 - int'(a);
            3'd3: r = int'(a & b);
            3'd4: r = int'(a | b);
            3'd5: r = int'(a ^ b);
            3'd6: r = (sa < sb) ? 1 : 0;
            default: r = (a == b) ? 1 : 0;
        endcase
        res = r[3:0];
        return {res, res == 4'd0, carry, ovf};
    endfunction

    task automatic apply_alu(input logic [2:0] op, input logic [7:0] data,
                             input logic [3:0] res, input logic [2:0] flags);
        @(posedge clk);
        sw <= data;
        alu_fnselec <= op;
        @(negedge clk);
        check_value("alu_res", alu_res, res);
        check_value("alu_zero", alu_zero, flags[2]);
        check_value("alu_carry", alu_carry, flags[1]);
        check_value("alu_overflow", alu_overflow, flags[0]);
        @(negedge clk);  // Display registers one cycle later
        check_value("seg5", seg5, SEG_HEX[res]);
        check_value("seg7", seg7, {flags == 3'd0, SEG_HEX[flags][6:0]});
    endtask

    task automatic send_frame(input logic [7:0] value, input logic [1:0] fault);
        logic [10:0] bits;
        bits = {fault != 2'd2, (~^value) ^ (fault == 2'd1), value, 1'b0};
        for (int i = 0; i < `PS2_FRAME_BITS; i++) begin
            @(posedge clk);
            ps2_data <= bits[i];
            repeat (PS2_HALF / 2) @(posedge clk);
            ps2_clk <= 1'b0;
            repeat (PS2_HALF) @(posedge clk);
            ps2_clk <= 1'b1;
            repeat (PS2_HALF / 2) @(posedge clk);
        end
        ps2_data <= 1'b1;
    endtask

    task automatic apply_key(input vector_t v);
        int r0;
        int e0;
        int waited;
        r0 = ready_cnt;
        e0 = error_cnt;
        send_frame(v.data, v.fault);
        waited = 0;
        while (ready_cnt == r0 && error_cnt == e0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (waited == 20) begin
            $display("No key_ready or key_error pulse followed the frame");
            $display("tests failed");
            $fatal(1, "missing pulse");
        end
        repeat (4) @(negedge clk);
        if (!v.err) last_code = v.data;
        check_value("key_ready pulses", ready_cnt - r0, !v.err);
        check_value("key_error pulses", error_cnt - e0, v.err);
        check_value("key_code", key_code, last_code);
        check_value("seg3", seg3, SEG_HEX[last_code[3:0]]);
        check_value("seg4", seg4, SEG_HEX[last_code[7:4]]);
    endtask

    task automatic check_counts(input int k);
        int up;
        up = k % `COUNT_WRAP;
        check_value("inc_count", inc_count, up);
        check_value("dec_count", dec_count, (8 - k % 8) % 8);
        check_value("seg0", seg0, SEG_HEX[up % 10]);
        check_value("seg1", seg1, SEG_HEX[up / 10]);
        check_value("seg2", seg2, SEG_HEX[(8 - k % 8) % 8]);
    endtask

    initial begin
        logic [7:0] op_bits;
        logic [7:0] data;
        logic [6:0] model;
        rst = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        sw = 8'h00;
        alu_fnselec = 3'd0;
        counter_en = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // ******************************
        // Counters from reset
        // ******************************
        repeat (4) @(posedge clk);
        @(negedge clk);
        check_value("key_code", key_code, 8'h00);
        check_value("seg3", seg3, SEG_HEX[0]);
        check_value("seg4", seg4, SEG_HEX[0]);
        check_value("seg6", seg6, 8'hFF);
        check_counts(0);
        for (int k = 1; k <= COUNT_TICKS; k++) begin
            repeat (`TICK_DIV) @(posedge clk);
            @(negedge clk);
            check_counts(k);
        end
        @(posedge clk);
        counter_en <= 1'b0;
        repeat (3 * `TICK_DIV) @(posedge clk);
        @(negedge clk);
        check_counts(COUNT_TICKS);  // Enable low, both counts hold

        // ******************************
        // Table, then random ALU vectors
        // ******************************
        for (int n = 0; n < NUM_VEC; n++) begin
            if (vectors[n].is_key) apply_key(vectors[n]);
            else apply_alu(vectors[n].op, vectors[n].data, vectors[n].res, vectors[n].flags);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            take_bits(3, op_bits);
            take_bits(8, data);
            model = alu_model(op_bits[2:0], data[3:0], data[7:4]);
            apply_alu(op_bits[2:0], data, model[6:3], model[2:0]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+.
board_pkg.sv
ps2_keyboard.sv
tick_counter.sv
alu_4bit.sv
seg_display.sv
top.sv
tb_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_top -f src.f \
    || { echo "Build failed"; exit 1; }
out=$(./obj_dir/Vtb_top 2>&1)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
